//--- verilog/fetch_pkg.sv
// sizes for a 64-line ROM with a fixed 3-cycle read; fetch addresses wrap every 512 bytes
package fetch_pkg;

  //////////////////////////////
  // addresses
  //////////////////////////////

  localparam int pc_width = 64;                 // byte address, bits 1:0 always zero
  typedef logic [pc_width-1:0] pc_t;

  localparam int rom_lines       = 64;          // 64-bit lines in the instruction ROM
  localparam int line_addr_width = $clog2(rom_lines);
  localparam int line_lsb        = 3;           // 8 bytes per line, index starts at pc bit 3
  typedef logic [line_addr_width-1:0] line_addr_t;

  //////////////////////////////
  // memory timing
  //////////////////////////////

  // cycles from the ROM read strobe until the line may be used
  localparam int imem_latency = 3;
  localparam int timer_width  = $clog2(imem_latency + 1); // must hold imem_latency itself

  //////////////////////////////
  // fetch FSM encoding
  //////////////////////////////

  localparam logic [1:0] st_fetch_issue    = 2'd0; // strobe the ROM, start the timer
  localparam logic [1:0] st_fetch_wait     = 2'd1; // ROM access in progress
  localparam logic [1:0] st_deliver        = 2'd2; // item held at the output
  // issue cycle that follows a redirect, the PC already holds the target
  localparam logic [1:0] st_redirect_flush = 2'd3;

endpackage

//--- verilog/isa_pkg.sv
// a memory line carries two 32-bit instructions, the lower address in the low half
package isa_pkg;

  //////////////////////////////
  // words
  //////////////////////////////

  localparam int inst_width = 32;               // one instruction
  localparam int line_width = 2 * inst_width;   // one ROM line

  typedef logic [inst_width-1:0] inst_t;

  //////////////////////////////
  // memory line
  //////////////////////////////

  // slot order follows the byte address within the line
  typedef struct packed {
    inst_t hi_slot;                             // pc bit 2 set, line bits 63:32
    inst_t lo_slot;                             // pc bit 2 clear, line bits 31:0
  } inst_pair_t;

  // the ROM fills raw, the fetch select reads pair
  typedef union packed {
    logic [line_width-1:0] raw;
    inst_pair_t            pair;
  } mem_line_u;

endpackage

//--- verilog/latency_timer.sv
// done pulses exactly imem_latency cycles after start; a new start reloads the count
`timescale 1ns/1ns

module latency_timer
  import fetch_pkg::*;
(
  input  logic clock,
  input  logic reset,
  input  logic start,   // ROM read issued this cycle
  input  logic cancel,  // redirect, forget the running access
  output logic done     // ROM line usable this cycle
);

  logic [timer_width-1:0] count; // zero means idle

  //////////////////////////////
  // down counter
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (reset || cancel) begin
      count <= '0;
    end else if (start) begin
      count <= timer_width'(imem_latency);
    end else if (count != '0) begin
      count <= count - 1'b1;                 // stops at zero after done
    end
  end

  // last cycle of the access is the one at count 1
  assign done = (count == timer_width'(1));

endmodule

//--- verilog/pc_generator.sv
// pc is the address of the item at the output, or of the fetch under way; targets are word aligned
`timescale 1ns/1ns

module pc_generator
  import fetch_pkg::*;
(
  input  logic clock,
  input  logic reset,
  input  logic advance,      // move to pc+4
  input  logic redirect,     // load the branch target, wins over advance
  input  pc_t  redirect_pc,
  output pc_t  pc,
  output pc_t  next_pc,
  output logic same_line     // pc+4 stays inside the current line
);

  pc_t pc_reg;

  //////////////////////////////
  // pc register
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      pc_reg <= '0;                          // fetch starts at address 0
    end else if (redirect) begin
      pc_reg <= {redirect_pc[pc_width-1:2], 2'b00}; // drop byte offset
    end else if (advance) begin
      pc_reg <= next_pc;
    end
  end

  assign pc      = pc_reg;
  assign next_pc = pc_reg + pc_width'(4);    // sequential successor

  // lower slot now, so the successor is the upper slot of the same line
  assign same_line = ~pc_reg[2];

endmodule

//--- verilog/imem_rom.sv
// contents come from program.hex (64 lines of 16 hex digits); line holds between reads
`timescale 1ns/1ns

module imem_rom
  import fetch_pkg::*;
  import isa_pkg::*;
(
  input  logic       clock,
  input  logic       read,   // sample addr on this edge
  input  line_addr_t addr,   // line index, pc bits 8:3
  output mem_line_u  line
);

  logic [line_width-1:0] rom [rom_lines]; // one entry per 64-bit line

  //////////////////////////////
  // image
  //////////////////////////////

  initial begin
    $readmemh("program.hex", rom);
  end

  //////////////////////////////
  // registered read
  //////////////////////////////

  // the read data sits in line until the next strobe, the fetch timer
  // decides when it may be used
  always_ff @(posedge clock) begin
    if (read) begin
      line.raw <= rom[addr];
    end
  end

endmodule

//--- verilog/fetch_out_buffer.sv
// output holds stable while valid and not taken; out_clear wins over out_load
`timescale 1ns/1ns

module fetch_out_buffer
  import fetch_pkg::*;
  import isa_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      line_load,  // rom_line is valid, item comes from it
  input  logic      out_load,   // register the next item
  input  logic      out_clear,  // drop the current item
  input  mem_line_u rom_line,
  input  pc_t       pc,
  input  pc_t       next_pc,
  output logic      inst_valid,
  output inst_t     inst,
  output pc_t       inst_pc,
  output pc_t       inst_npc
);

  mem_line_u held_line;  // line of the item at the output
  mem_line_u src_line;
  pc_t       item_pc;    // address of the item being loaded
  pc_t       item_npc;

  always_ff @(posedge clock) begin
    if (line_load) begin
      held_line <= rom_line;
    end
  end

  //////////////////////////////
  // item select
  //////////////////////////////

  // fresh line: item is at pc; reload from the held line happens on the
  // transfer edge while pc still names the old item, so the item is at next_pc
  assign src_line = line_load ? rom_line : held_line;
  assign item_pc  = line_load ? pc : next_pc;
  assign item_npc = item_pc + pc_width'(4);

  always_ff @(posedge clock) begin
    if (out_load) begin
      inst     <= item_pc[2] ? src_line.pair.hi_slot : src_line.pair.lo_slot;
      inst_pc  <= item_pc;   // keeps counting past the 512-byte wrap
      inst_npc <= item_npc;
    end
  end

  //////////////////////////////
  // valid flag
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      inst_valid <= 1'b0;
    end else if (out_clear) begin
      inst_valid <= 1'b0;                    // redirect, or last slot taken
    end else if (out_load) begin
      inst_valid <= 1'b1;
    end
  end

endmodule

//--- verilog/fetch_control.sv
// one ROM fetch in flight; a redirect beats everything, including a transfer in the same cycle
`timescale 1ns/1ns

module fetch_control
  import fetch_pkg::*;
(
  input  logic clock,
  input  logic reset,
  input  logic redirect_valid,  // taken branch from retire, never refused
  input  logic inst_ready,      // downstream accepts the held item
  input  logic timer_done,      // ROM line is valid this cycle
  input  logic same_line,       // next pc sits in the upper half of the held line
  input  logic inst_valid,      // output register holds an item
  output logic timer_start,
  output logic rom_read,
  output logic line_load,       // capture the ROM line
  output logic out_load,        // load a new item into the output register
  output logic out_clear,       // drop the output item
  output logic pc_advance,
  output logic pc_redirect
);

  logic [1:0] state;
  logic [1:0] state_next;
  logic       transfer;

  assign transfer = inst_valid & inst_ready; // item leaves on this edge

  //////////////////////////////
  // state register
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_fetch_issue;               // first fetch starts at pc 0
    end else begin
      state <= state_next;
    end
  end

  //////////////////////////////
  // next state and strobes
  //////////////////////////////

  always_comb begin
    state_next  = state;
    timer_start = 1'b0;
    rom_read    = 1'b0;
    line_load   = 1'b0;
    out_load    = 1'b0;
    out_clear   = redirect_valid;            // a redirect empties the output
    pc_advance  = 1'b0;
    pc_redirect = redirect_valid;            // also cancels the timer

    if (redirect_valid) begin
      // fetch in progress is abandoned, its ROM line is never loaded
      state_next = st_redirect_flush;
    end else begin
      case (state)
        st_fetch_issue, st_redirect_flush: begin
          rom_read    = 1'b1;                // ROM samples the line index of pc
          timer_start = 1'b1;
          state_next  = st_fetch_wait;
        end
        st_fetch_wait: begin
          if (timer_done) begin
            line_load  = 1'b1;               // keep the line for the second slot
            out_load   = 1'b1;               // valid rises on this edge
            state_next = st_deliver;
          end
        end
        st_deliver: begin
          if (transfer) begin
            pc_advance = 1'b1;
            if (same_line) begin
              out_load = 1'b1;               // upper slot follows with no bubble
            end else begin
              out_clear  = 1'b1;             // line used up, go back to the ROM
              state_next = st_fetch_issue;
            end
          end
          // no transfer: hold everything, output stays stable
        end
        default: begin
          state_next = st_fetch_issue;
        end
      endcase
    end
  end

endmodule

//--- verilog/fetch_top.sv
// fetch front end; ROM index is pc bits 8:3, one read outstanding, redirect needs no ready
`timescale 1ns/1ns

module fetch_top
  import fetch_pkg::*;
  import isa_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  logic  redirect_valid,  // taken branch from retire
  input  pc_t   redirect_pc,
  input  logic  inst_ready,      // downstream takes the item
  output logic  inst_valid,
  output inst_t inst,
  output pc_t   inst_pc,
  output pc_t   inst_npc         // inst_pc + 4
);

  // FSM strobes
  logic      timer_start;
  logic      rom_read;
  logic      line_load;
  logic      out_load;
  logic      out_clear;
  logic      pc_advance;
  logic      pc_redirect;
  // status back to the FSM
  logic      timer_done;
  logic      same_line;
  // datapath
  pc_t       pc;
  pc_t       next_pc;
  mem_line_u rom_line;

  //////////////////////////////
  // control
  //////////////////////////////

  fetch_control u_control (
    .clock, .reset, .redirect_valid, .inst_ready, .timer_done, .same_line, .inst_valid,
    .timer_start, .rom_read, .line_load, .out_load, .out_clear, .pc_advance, .pc_redirect
  );

  latency_timer u_timer (
    .clock, .reset, .start(timer_start), .cancel(pc_redirect), .done(timer_done)
  );

  //////////////////////////////
  // datapath
  //////////////////////////////

  pc_generator u_pc (
    .clock, .reset, .advance(pc_advance), .redirect(pc_redirect), .redirect_pc,
    .pc, .next_pc, .same_line
  );

  imem_rom u_rom (
    .clock, .read(rom_read), .addr(pc[line_addr_width+line_lsb-1:line_lsb]), .line(rom_line)
  );

  fetch_out_buffer u_out (
    .clock, .reset, .line_load, .out_load, .out_clear, .rom_line, .pc, .next_pc,
    .inst_valid, .inst, .inst_pc, .inst_npc
  );

endmodule

//--- testbench/fetch_checks.svh
// compares for fetch_tb, included after its package imports; a mismatch stops the run
`ifndef fetch_checks_svh
`define fetch_checks_svh

  //////////////////////////////
  // fail path
  //////////////////////////////

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  //////////////////////////////
  // typed compares
  //////////////////////////////

  task automatic check_inst(input string what, input inst_t expected, input inst_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: expected %08h, actual %08h", what, expected, actual);
      abort_run();
    end
  endtask

  // used for inst_pc and inst_npc alike
  task automatic check_pc(input string what, input pc_t expected, input pc_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: expected %016h, actual %016h", what, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_flag(input string what, input bit expected, input bit actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: expected %0b, actual %0b", what, expected, actual);
      abort_run();
    end
  endtask

`endif

//--- testbench/fetch_tb.sv
// table driven test of fetch_top; reads program.hex from the run directory, ready is random per row
`timescale 1ns/1ns

module fetch_tb
  import fetch_pkg::*;
  import isa_pkg::*;
();

  //////////////////////////////
  // DUT and clock
  //////////////////////////////

  logic  clock;
  logic  reset;
  logic  redirect_valid;
  pc_t   redirect_pc;
  logic  inst_ready;
  logic  inst_valid;
  inst_t inst;
  pc_t   inst_pc;
  pc_t   inst_npc;

  fetch_top DUT (
    .clock, .reset, .redirect_valid, .redirect_pc, .inst_ready,
    .inst_valid, .inst, .inst_pc, .inst_npc
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;                // 8 ns period
  end

  `include "fetch_checks.svh"

  //////////////////////////////
  // stimulus table
  //////////////////////////////

  localparam int num_rows = 8;

  // per row: name, redirect or not, target, transfers to take, ready percent, stall first
  string row_name [num_rows] = '{
    "reset_sequence", "slow_ready", "unaligned_target", "upper_slot_target",
    "wrap_at_508", "redirect_while_stalled", "full_rate_run", "redirect_at_full_rate"
  };
  bit  row_redirect [num_rows] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1};
  pc_t row_target [num_rows] = '{
    64'h0, 64'h0, 64'h123, 64'h74, 64'h1f4, 64'h1_0000_01fb, 64'h0, 64'hae
  };
  int  row_count [num_rows] = '{12, 20, 10, 9, 8, 6, 15, 10};
  int  row_ready [num_rows] = '{100, 30, 70, 60, 80, 50, 100, 100};
  bit  row_park  [num_rows] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};

  //////////////////////////////
  // reference model
  //////////////////////////////

  mem_line_u image [rom_lines];               // same ROM image as the DUT

  // line from pc bits 8:3, slot from pc bit 2
  function automatic inst_t model_inst(input pc_t p);
    mem_line_u l;
    l = image[p[8:3]];
    return p[2] ? l.pair.hi_slot : l.pair.lo_slot;
  endfunction

  pc_t   expect_pc;                           // pc of the next item downstream should take
  bit    held_last;                           // an item sat unaccepted last cycle
  bit    redirect_last;                       // a redirect went in last cycle
  inst_t held_inst;
  pc_t   held_pc;
  pc_t   held_npc;
  string test_name;
  int    cycle_count = 0;
  int    cycle_limit;

  //////////////////////////////
  // timeout
  //////////////////////////////

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout: the run hung, no finish after %0d cycles", cycle_count);
      abort_run();
    end
  end

  //////////////////////////////
  // one cycle, entered and left on a falling edge
  //////////////////////////////

  task automatic run_cycle(input bit redir, input pc_t target, input int pct, output bit took);
    bit rdy;
    // outputs last moved on the rising edge, so they are settled here
    if (redirect_last) begin
      check_flag({test_name, " inst_valid after redirect"}, 1'b0, inst_valid);
    end
    if (held_last) begin
      check_flag({test_name, " inst_valid while stalled"}, 1'b1, inst_valid);
      check_inst({test_name, " inst while stalled"}, held_inst, inst);
      check_pc({test_name, " inst_pc while stalled"}, held_pc, inst_pc);
      check_pc({test_name, " inst_npc while stalled"}, held_npc, inst_npc);
    end
    rdy = (int'($urandom % 100) < pct);
    inst_ready     = rdy;
    redirect_valid = redir;
    redirect_pc    = target;
    took = inst_valid && rdy && !redir;       // redirect beats the transfer
    if (took) begin
      check_inst({test_name, " inst"}, model_inst(expect_pc), inst);
      check_pc({test_name, " inst_pc"}, expect_pc, inst_pc);
      check_pc({test_name, " inst_npc"}, expect_pc + pc_t'(4), inst_npc);
      expect_pc = expect_pc + pc_t'(4);
    end
    held_last     = inst_valid && !rdy && !redir;
    redirect_last = redir;
    held_inst     = inst;
    held_pc       = inst_pc;
    held_npc      = inst_npc;
    @(negedge clock);
  endtask

  //////////////////////////////
  // one table row
  //////////////////////////////

  task automatic apply_row(input int r);
    int done_count;
    bit took;
    test_name  = row_name[r];
    done_count = 0;
    if (row_park[r]) begin
      // ready low until an item waits, so the redirect hits a held output
      while (!inst_valid) begin
        run_cycle(1'b0, '0, 0, took);
      end
    end
    if (row_redirect[r]) begin
      run_cycle(1'b1, row_target[r], row_park[r] ? 0 : row_ready[r], took);
      expect_pc = row_target[r] & ~pc_t'(3);  // target word aligned
    end
    while (done_count < row_count[r]) begin
      run_cycle(1'b0, '0, row_ready[r], took);
      if (took) begin
        done_count++;
      end
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    int total;
    int lowest;
    reset          = 1'b1;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    inst_ready     = 1'b0;
    held_last      = 1'b0;
    redirect_last  = 1'b0;
    expect_pc      = '0;                      // fetch starts at address 0
    test_name      = "reset";
    void'($urandom(27));
    $readmemh("program.hex", image);

    // worst case per item is a full fetch plus a bubble, stretched by the slowest ready
    total  = 0;
    lowest = 100;
    for (int r = 0; r < num_rows; r++) begin
      total += row_count[r];
      if (row_ready[r] < lowest) begin
        lowest = row_ready[r];
      end
    end
    cycle_limit = total * (imem_latency + 2) * 100 / lowest + 200;

    repeat (5) @(negedge clock);              // 5 rising edges under reset
    reset = 1'b0;
    check_flag("reset inst_valid", 1'b0, inst_valid);

    for (int r = 0; r < num_rows; r++) begin
      apply_row(r);
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- program.hex
// one 64-bit line per row: upper word is pc bit 2 set, lower word pc bit 2 clear
// each word holds its byte address in the top half and 5A plus its word index below
00045A0100005A00
000C5A0300085A02
00145A0500105A04
001C5A0700185A06
00245A0900205A08
002C5A0B00285A0A
00345A0D00305A0C
003C5A0F00385A0E
00445A1100405A10
004C5A1300485A12
00545A1500505A14
005C5A1700585A16
00645A1900605A18
006C5A1B00685A1A
00745A1D00705A1C
007C5A1F00785A1E
00845A2100805A20
008C5A2300885A22
00945A2500905A24
009C5A2700985A26
00A45A2900A05A28
00AC5A2B00A85A2A
00B45A2D00B05A2C
00BC5A2F00B85A2E
00C45A3100C05A30
00CC5A3300C85A32
00D45A3500D05A34
00DC5A3700D85A36
00E45A3900E05A38
00EC5A3B00E85A3A
00F45A3D00F05A3C
00FC5A3F00F85A3E
01045A4101005A40
010C5A4301085A42
01145A4501105A44
011C5A4701185A46
01245A4901205A48
012C5A4B01285A4A
01345A4D01305A4C
013C5A4F01385A4E
01445A5101405A50
014C5A5301485A52
01545A5501505A54
015C5A5701585A56
01645A5901605A58
016C5A5B01685A5A
01745A5D01705A5C
017C5A5F01785A5E
01845A6101805A60
018C5A6301885A62
01945A6501905A64
019C5A6701985A66
01A45A6901A05A68
01AC5A6B01A85A6A
01B45A6D01B05A6C
01BC5A6F01B85A6E
01C45A7101C05A70
01CC5A7301C85A72
01D45A7501D05A74
01DC5A7701D85A76
01E45A7901E05A78
01EC5A7B01E85A7A
01F45A7D01F05A7C
01FC5A7F01F85A7E

//--- files.f
+incdir+testbench
verilog/fetch_pkg.sv
verilog/isa_pkg.sv
verilog/latency_timer.sv
verilog/pc_generator.sv
verilog/imem_rom.sv
verilog/fetch_out_buffer.sv
verilog/fetch_control.sv
verilog/fetch_top.sv
testbench/fetch_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds fetch_tb with Verilator and runs it from the project root, where program.hex lives
cd "$(dirname "$0")" &&
  verilator --binary --timing -Wno-fatal -f files.f --top-module fetch_tb -o fetch_sim &&
  ./obj_dir/fetch_sim &&
  echo "simulation finished" ||
  { echo "build or simulation failed"; exit 1; }
